// ==== noc_pkg.sv ====
package noc_pkg;

    // node grid sizing, 4x4x4
    localparam int COORD_W = 2;
    localparam int PAYLOAD_W = 32;

    // input queue entries, also the upstream credit count after reset
    localparam int QUEUE_DEPTH = 5;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // output credits after reset, matches the downstream queue depth
    localparam int CREDIT_INIT = 5;
    localparam int CREDIT_W = $clog2(CREDIT_INIT + 1);

    // reduce command fields
    localparam int GROUP_W = 6;
    localparam int OPERAND_W = 24;

    // direction codes as used on the board links
    typedef enum logic [2:0] {
        DIR_INJECT = 3'd0,
        DIR_XPOS   = 3'd1,
        DIR_YPOS   = 3'd2,
        DIR_ZPOS   = 3'd3,
        DIR_XNEG   = 3'd4,
        DIR_YNEG   = 3'd5,
        DIR_ZNEG   = 3'd6,
        DIR_EJECT  = 3'd7
    } dir_t;

    typedef enum logic {
        KIND_DATA   = 1'b0,
        KIND_REDUCE = 1'b1
    } flit_kind_t;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_MAX = 2'd1,
        OP_MIN = 2'd2
    } reduce_op_t;

    // 2 + 6 + 24 bits
    typedef struct packed {
        reduce_op_t             op;
        logic [GROUP_W-1:0]     group_size;
        logic [OPERAND_W-1:0]   operand;
    } reduce_cmd_t;

    // kind field picks the view
    typedef union packed {
        logic [PAYLOAD_W-1:0]   data;
        reduce_cmd_t            cmd;
    } payload_u;

    // 1 + 3*2 + 32 = 39 bits
    typedef struct packed {
        flit_kind_t             kind;
        logic [COORD_W-1:0]     dst_x;
        logic [COORD_W-1:0]     dst_y;
        logic [COORD_W-1:0]     dst_z;
        payload_u               payload;
    } flit_t;

endpackage

// ==== flit_if.sv ====
interface flit_if import noc_pkg::*; ();

    // one flit stage between router blocks
    flit_t  flit;
    logic   valid;
    // direction tag, meaning depends on the stage
    dir_t   dir;
    // source holds its flit while this is high
    logic   stall;

    // transfer when valid && !stall
    modport src (
        output flit,
        output valid,
        output dir,
        input  stall
    );

    modport dst (
        input  flit,
        input  valid,
        input  dir,
        output stall
    );

endinterface

// ==== input_queue.sv ====
module input_queue import noc_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  flit_t   in_flit,
    input  logic    in_valid,
    output logic    in_credit,
    flit_if.src     deq
);

    // storage
    flit_t mem [QUEUE_DEPTH];

    // pointers and fill level
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;

    logic full;
    logic push;
    logic pop;

    assign full = (count == QUEUE_CNT_W'(QUEUE_DEPTH));
    // overrun flit is lost, upstream must respect its credits
    assign push = in_valid && !full;
    assign pop  = deq.valid && !deq.stall;

    // first-word fall-through from the head entry
    assign deq.flit  = mem[rd_ptr];
    assign deq.valid = (count != '0);
    // flits on this queue arrived over the xpos link
    assign deq.dir   = DIR_XPOS;

    // one credit back upstream per pop
    assign in_credit = pop;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                // depth is not a power of two, wrap by hand
                wr_ptr <= (wr_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + QUEUE_CNT_W'(push) - QUEUE_CNT_W'(pop);
        end
    end

    // entry write
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_flit;
        end
    end

endmodule

// ==== reduce_unit.sv ====
module reduce_unit import noc_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    flit_if.dst     up,
    flit_if.src     down
);

    // output stage register
    flit_t                  out_flit;
    logic                   out_valid;

    // running group state
    flit_t                  head;
    logic [OPERAND_W-1:0]   acc;
    logic [GROUP_W-1:0]     cnt;

    reduce_cmd_t            cmd;
    logic [OPERAND_W-1:0]   acc_next;
    logic [GROUP_W-1:0]     cnt_next;
    flit_t                  result;
    logic                   accept;
    logic                   is_reduce;
    logic                   first;
    logic                   last;

    // hold off upstream only while our output is blocked
    assign up.stall  = out_valid && down.stall;
    assign accept    = up.valid && !up.stall;

    assign is_reduce = (up.flit.kind == KIND_REDUCE);
    assign cmd       = up.flit.payload.cmd;
    assign first     = (cnt == '0);
    assign cnt_next  = cnt + 1'b1;
    // group size 0 or 1 closes on the first flit
    assign last      = (cnt_next >= cmd.group_size);

    always_comb begin
        if (first) begin
            acc_next = cmd.operand;
        end else begin
            case (cmd.op)
                OP_MAX:  acc_next = (cmd.operand > acc) ? cmd.operand : acc;
                OP_MIN:  acc_next = (cmd.operand < acc) ? cmd.operand : acc;
                default: acc_next = acc + cmd.operand;
            endcase
        end
    end

    // result goes out as data, addressed like the first flit of the group
    always_comb begin
        result = first ? up.flit : head;
        result.kind = KIND_DATA;
        result.payload.data = PAYLOAD_W'(acc_next);
    end

    assign down.flit  = out_flit;
    assign down.valid = out_valid;
    assign down.dir   = DIR_XPOS;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            cnt       <= '0;
        end else begin
            if (accept && (!is_reduce || last)) begin
                out_valid <= 1'b1;
            end else if (!down.stall) begin
                out_valid <= 1'b0;
            end
            if (accept && is_reduce) begin
                cnt <= last ? '0 : cnt_next;
            end
        end
    end

    // payload and accumulator
    always_ff @(posedge clk) begin
        if (accept) begin
            if (!is_reduce) begin
                out_flit <= up.flit;
            end else begin
                acc <= acc_next;
                if (first) begin
                    head <= up.flit;
                end
                if (last) begin
                    out_flit <= result;
                end
            end
        end
    end

endmodule

// ==== route_comp.sv ====
module route_comp import noc_pkg::*; #(
    parameter logic [COORD_W-1:0] cur_x = '0,
    parameter logic [COORD_W-1:0] cur_y = '0,
    parameter logic [COORD_W-1:0] cur_z = '0
) (
    input  logic    clk,
    input  logic    rst_n,
    flit_if.dst     up,
    flit_if.src     down,
    output flit_t   eject_flit,
    output logic    eject_valid
);

    // network stage register
    flit_t  down_flit;
    dir_t   down_dir;
    logic   down_valid;

    dir_t   route_dir;
    logic   is_eject;
    logic   accept;

    // dimension order x, y, z on a plain mesh
    always_comb begin
        if (up.flit.dst_x > cur_x) begin
            route_dir = DIR_XPOS;
        end else if (up.flit.dst_x < cur_x) begin
            route_dir = DIR_XNEG;
        end else if (up.flit.dst_y > cur_y) begin
            route_dir = DIR_YPOS;
        end else if (up.flit.dst_y < cur_y) begin
            route_dir = DIR_YNEG;
        end else if (up.flit.dst_z > cur_z) begin
            route_dir = DIR_ZPOS;
        end else if (up.flit.dst_z < cur_z) begin
            route_dir = DIR_ZNEG;
        end else begin
            route_dir = DIR_EJECT;
        end
    end

    assign is_eject = (route_dir == DIR_EJECT);
    // eject path never blocks, so only network flits see the stall
    assign up.stall = down_valid && down.stall && !is_eject;
    assign accept   = up.valid && !up.stall;

    assign down.flit  = down_flit;
    assign down.dir   = down_dir;
    assign down.valid = down_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            down_valid  <= 1'b0;
            eject_valid <= 1'b0;
        end else begin
            eject_valid <= accept && is_eject;
            if (accept && !is_eject) begin
                down_valid <= 1'b1;
            end else if (!down.stall) begin
                down_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !is_eject) begin
            down_flit <= up.flit;
            down_dir  <= route_dir;
        end
        if (accept && is_eject) begin
            eject_flit <= up.flit;
        end
    end

endmodule

// ==== output_stage.sv ====
module output_stage import noc_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    flit_if.dst     up,
    input  flit_t   inject_flit,
    input  dir_t    inject_dir,
    input  logic    inject_valid,
    output logic    inject_ready,
    output flit_t   out_flit,
    output dir_t    out_dir,
    output logic    out_valid,
    input  logic    out_credit
);

    // credits left at the downstream queue
    logic [CREDIT_W-1:0] credits;

    logic has_credit;
    logic inject_go;
    logic net_go;

    assign has_credit   = (credits != '0);
    assign inject_ready = has_credit;

    // kernel traffic wins the link
    assign inject_go = inject_valid && inject_ready;

    // network flit waits on inject or on an empty credit pool
    assign up.stall = inject_go || !has_credit;
    assign net_go   = up.valid && !up.stall;

    assign out_valid = inject_go || net_go;

    always_comb begin
        if (inject_go) begin
            out_flit = inject_flit;
            out_dir  = inject_dir;
        end else begin
            out_flit = up.flit;
            out_dir  = up.dir;
        end
    end

    // spend one per flit sent, regain one per credit pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= CREDIT_W'(CREDIT_INIT);
        end else begin
            credits <= credits + CREDIT_W'(out_credit) - CREDIT_W'(out_valid);
        end
    end

endmodule

// ==== router_top.sv ====
module router_top import noc_pkg::*; #(
    parameter logic [COORD_W-1:0] cur_x = '0,
    parameter logic [COORD_W-1:0] cur_y = '0,
    parameter logic [COORD_W-1:0] cur_z = '0
) (
    input  logic    clk,
    input  logic    rst_n,
    // xpos network input
    input  flit_t   in_flit,
    input  logic    in_valid,
    output logic    in_credit,
    // network output link
    output flit_t   out_flit,
    output dir_t    out_dir,
    output logic    out_valid,
    input  logic    out_credit,
    // kernel eject
    output flit_t   eject_flit,
    output logic    eject_valid,
    // kernel inject
    input  flit_t   inject_flit,
    input  dir_t    inject_dir,
    input  logic    inject_valid,
    output logic    inject_ready
);

    // queue to reduce, reduce to route, route to output
    flit_if q2r ();
    flit_if r2c ();
    flit_if c2o ();

    input_queue i_input_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_flit   (in_flit),
        .in_valid  (in_valid),
        .in_credit (in_credit),
        .deq       (q2r.src)
    );

    reduce_unit i_reduce_unit (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (q2r.dst),
        .down  (r2c.src)
    );

    route_comp #(
        .cur_x (cur_x),
        .cur_y (cur_y),
        .cur_z (cur_z)
    ) i_route_comp (
        .clk         (clk),
        .rst_n       (rst_n),
        .up          (r2c.dst),
        .down        (c2o.src),
        .eject_flit  (eject_flit),
        .eject_valid (eject_valid)
    );

    output_stage i_output_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .up           (c2o.dst),
        .inject_flit  (inject_flit),
        .inject_dir   (inject_dir),
        .inject_valid (inject_valid),
        .inject_ready (inject_ready),
        .out_flit     (out_flit),
        .out_dir      (out_dir),
        .out_valid    (out_valid),
        .out_credit   (out_credit)
    );

endmodule

// ==== tb_router_top.sv ====
module tb_router_top import noc_pkg::*; ();

    localparam int NUM_TESTS = 7;
    localparam int MODE_DATA = 0;
    localparam int MODE_EJECT = 1;
    localparam int MODE_REDUCE = 2;
    // cycles the output link is starved of credits in a stall test
    localparam int HOLD_CYCLES = 60;
    localparam logic [COORD_W-1:0] NODE_X = COORD_W'(1);
    localparam logic [COORD_W-1:0] NODE_Y = COORD_W'(1);
    localparam logic [COORD_W-1:0] NODE_Z = COORD_W'(1);

    // test table as parallel arrays indexed by test
    string      test_name [NUM_TESTS] = '{"route_data", "eject_local", "reduce_add",
        "reduce_max", "reduce_min_single", "inject_first", "credit_stall"};
    int         test_mode [NUM_TESTS] = '{MODE_DATA, MODE_EJECT, MODE_REDUCE,
        MODE_REDUCE, MODE_REDUCE, MODE_DATA, MODE_DATA};
    // network flits sent and the reduce group size
    int         test_flits [NUM_TESTS] = '{16, 8, 12, 9, 4, 6, 14};
    int         test_group [NUM_TESTS] = '{0, 0, 4, 3, 1, 0, 0};
    reduce_op_t test_op [NUM_TESTS] = '{OP_ADD, OP_ADD, OP_ADD, OP_MAX, OP_MIN,
        OP_ADD, OP_ADD};
    int         test_inject [NUM_TESTS] = '{0, 0, 0, 0, 0, 5, 0};
    bit         test_hold [NUM_TESTS] = '{0, 0, 0, 0, 0, 0, 1};

    logic   clk = 1'b0;
    logic   rst_n;
    flit_t  in_flit;
    logic   in_valid;
    logic   in_credit;
    flit_t  out_flit;
    dir_t   out_dir;
    logic   out_valid;
    logic   out_credit;
    flit_t  eject_flit;
    logic   eject_valid;
    flit_t  inject_flit;
    dir_t   inject_dir;
    logic   inject_valid;
    logic   inject_ready;

    int     seed = 38;
    int     errors = 0;
    string  cur_name = "reset";
    // stimulus still to be driven
    flit_t  in_q [$];
    flit_t  inj_q [$];
    dir_t   inj_dir_q [$];
    // expected streams kept apart so each keeps its own order
    flit_t  exp_out [$];
    dir_t   exp_dir [$];
    flit_t  exp_inj [$];
    dir_t   exp_inj_dir [$];
    flit_t  exp_ej [$];
    // upstream view of the input link
    int     tb_credits = QUEUE_DEPTH;
    int     credit_pulses = 0;
    int     flits_sent = 0;
    // flits on the output link not yet credited back
    int     owed = 0;
    int     held_sent = 0;
    bit     hold = 1'b0;

    always #10 clk = ~clk;

    router_top #(
        .cur_x (NODE_X),
        .cur_y (NODE_Y),
        .cur_z (NODE_Z)
    ) i_router_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_flit      (in_flit),
        .in_valid     (in_valid),
        .in_credit    (in_credit),
        .out_flit     (out_flit),
        .out_dir      (out_dir),
        .out_valid    (out_valid),
        .out_credit   (out_credit),
        .eject_flit   (eject_flit),
        .eject_valid  (eject_valid),
        .inject_flit  (inject_flit),
        .inject_dir   (inject_dir),
        .inject_valid (inject_valid),
        .inject_ready (inject_ready)
    );

    task automatic check_flit(string name, flit_t exp, flit_t act);
        if (exp !== act) begin
            errors++;
            $display("** Error %s: expected flit %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_dir(string name, dir_t exp, dir_t act);
        if (exp !== act) begin
            errors++;
            $display("** Error %s: expected dir %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            errors++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (exp != act) begin
            errors++;
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // mesh dimension order x then y then z
    function automatic dir_t expect_dir(flit_t f);
        if (f.dst_x > NODE_X) return DIR_XPOS;
        if (f.dst_x < NODE_X) return DIR_XNEG;
        if (f.dst_y > NODE_Y) return DIR_YPOS;
        if (f.dst_y < NODE_Y) return DIR_YNEG;
        if (f.dst_z > NODE_Z) return DIR_ZPOS;
        if (f.dst_z < NODE_Z) return DIR_ZNEG;
        return DIR_EJECT;
    endfunction

    function automatic logic [OPERAND_W-1:0] fold(reduce_op_t op,
            logic [OPERAND_W-1:0] acc, logic [OPERAND_W-1:0] v);
        case (op)
            OP_MAX:  return (v > acc) ? v : acc;
            OP_MIN:  return (v < acc) ? v : acc;
            default: return acc + v;
        endcase
    endfunction

    function automatic flit_t random_data(bit to_node);
        flit_t f;
        f.kind = KIND_DATA;
        f.dst_x = to_node ? NODE_X : COORD_W'($random(seed));
        f.dst_y = to_node ? NODE_Y : COORD_W'($random(seed));
        f.dst_z = to_node ? NODE_Z : COORD_W'($random(seed));
        f.payload.data = $random(seed);
        return f;
    endfunction

    task automatic expect_route(flit_t f);
        dir_t d;
        d = expect_dir(f);
        if (d == DIR_EJECT) begin
            exp_ej.push_back(f);
        end else begin
            exp_out.push_back(f);
            exp_dir.push_back(d);
        end
    endtask

    task automatic build_test(int t);
        flit_t f;
        flit_t head;
        logic [OPERAND_W-1:0] acc;
        dir_t d;
        for (int i = 0; i < test_flits[t]; i++) begin
            if (test_mode[t] == MODE_REDUCE) begin
                f = random_data(1'b0);
                f.kind = KIND_REDUCE;
                f.payload.cmd.op = test_op[t];
                f.payload.cmd.group_size = GROUP_W'(test_group[t]);
                f.payload.cmd.operand = OPERAND_W'($random(seed));
                // first flit of a group sets address and start value
                if (i % test_group[t] == 0) begin
                    head = f;
                    acc = f.payload.cmd.operand;
                end else begin
                    acc = fold(test_op[t], acc, f.payload.cmd.operand);
                end
                // one data flit per closed group
                if (i % test_group[t] == test_group[t] - 1) begin
                    head.kind = KIND_DATA;
                    head.payload.data = PAYLOAD_W'(acc);
                    expect_route(head);
                end
            end else begin
                f = random_data(test_mode[t] == MODE_EJECT);
                expect_route(f);
            end
            in_q.push_back(f);
        end
        for (int i = 0; i < test_inject[t]; i++) begin
            f = random_data(1'b0);
            d = dir_t'(3'(1 + ($random(seed) & 32'hff) % 6));
            inj_q.push_back(f);
            inj_dir_q.push_back(d);
            exp_inj.push_back(f);
            exp_inj_dir.push_back(d);
        end
    endtask

    // one clock of upstream and kernel driving
    task automatic drive_cycle();
        @(posedge clk);
        if (in_credit) begin
            credit_pulses++;
            tb_credits++;
        end
        if (tb_credits > QUEUE_DEPTH) begin
            errors++;
            $display("%s: router returned more credits than its queue holds", cur_name);
        end
        if (in_q.size() > 0 && tb_credits > 0) begin
            in_flit <= in_q.pop_front();
            in_valid <= 1'b1;
            tb_credits--;
            flits_sent++;
        end else begin
            in_valid <= 1'b0;
        end
        // inject flit was taken at this edge
        if (inject_valid && inject_ready) begin
            void'(inj_q.pop_front());
            void'(inj_dir_q.pop_front());
        end
        if (inj_q.size() > 0) begin
            inject_flit <= inj_q[0];
            inject_dir <= inj_dir_q[0];
            inject_valid <= 1'b1;
        end else begin
            inject_valid <= 1'b0;
        end
    endtask

    function automatic bit test_done();
        return in_q.size() == 0 && inj_q.size() == 0 && exp_out.size() == 0
            && exp_inj.size() == 0 && exp_ej.size() == 0 && owed == 0 && !hold;
    endfunction

    task automatic run_test(int t);
        int cycles;
        cur_name = test_name[t];
        build_test(t);
        held_sent = 0;
        hold = test_hold[t];
        cycles = 0;
        while (!test_done()) begin
            drive_cycle();
            cycles++;
            if (hold && cycles >= HOLD_CYCLES) begin
                if (held_sent > CREDIT_INIT) begin
                    errors++;
                    $display("%s: %0d flits left without credits returned", cur_name,
                        held_sent);
                end
                hold = 1'b0;
            end
        end
        // last credit pulses still reach the counters
        repeat (4) drive_cycle();
    endtask

    // output link, eject port and downstream credit return
    always @(posedge clk) begin
        if (!rst_n) begin
            out_credit <= 1'b0;
        end else begin
            // DUT credit count excludes the pulse now on out_credit
            check_bit({cur_name, " inject_ready"},
                (CREDIT_INIT - owed - int'(out_credit)) > 0, inject_ready);
            if (out_valid) begin
                if (hold) held_sent++;
                owed++;
                if (inject_valid && inject_ready) begin
                    if (exp_inj.size() == 0) begin
                        errors++;
                        $display("%s: inject flit sent with none pending", cur_name);
                    end else begin
                        check_flit(cur_name, exp_inj.pop_front(), out_flit);
                        check_dir(cur_name, exp_inj_dir.pop_front(), out_dir);
                    end
                end else if (exp_out.size() == 0) begin
                    errors++;
                    $display("%s: unexpected flit on the output link", cur_name);
                end else begin
                    check_flit(cur_name, exp_out.pop_front(), out_flit);
                    check_dir(cur_name, exp_dir.pop_front(), out_dir);
                end
            end
            if (eject_valid) begin
                if (exp_ej.size() == 0) begin
                    errors++;
                    $display("%s: unexpected flit on the eject port", cur_name);
                end else begin
                    check_flit(cur_name, exp_ej.pop_front(), eject_flit);
                end
            end
            // downstream frees its slots after random gaps
            if (owed > 0 && !hold && ($random(seed) & 3) != 0) begin
                out_credit <= 1'b1;
                owed--;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        in_flit = '0;
        in_valid = 1'b0;
        out_credit = 1'b0;
        inject_flit = '0;
        inject_dir = DIR_INJECT;
        inject_valid = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        // every accepted flit was popped exactly once
        check_count("in_credit_total", flits_sent, credit_pulses);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog allows 40 cycles per flit in the table
    initial begin
        int total;
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += test_flits[t] + test_inject[t];
        end
        repeat (total * 40) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", total * 40);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== router_top.f ====
noc_pkg.sv
flit_if.sv
input_queue.sv
reduce_unit.sv
route_comp.sv
output_stage.sv
router_top.sv
tb_router_top.sv

// ==== Makefile ====
SRCS := $(shell cat router_top.f)

.PHONY: run clean

all: run

obj_dir/Vtb_router_top: router_top.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f router_top.f --top-module tb_router_top

run: obj_dir/Vtb_router_top
	@out="$$(./obj_dir/Vtb_router_top)"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
